// ==== design/resp_pkg.sv ====
// Response path shared types
package resp_pkg;

  localparam int NUM_CLASSES = 6;

  typedef logic [7:0] tag_t;
  typedef logic [8:0] credits_t;

  // Command classes, encodings 6 and 7 are invalid
  typedef enum logic [2:0] {
    CMD_READ           = 3'd0,
    CMD_WRITE          = 3'd1,
    CMD_WED            = 3'd2,
    CMD_RESTART        = 3'd3,
    CMD_PREFETCH_READ  = 3'd4,
    CMD_PREFETCH_WRITE = 3'd5
  } cmd_class_t;

  // Host response codes
  typedef enum logic [7:0] {
    RESP_DONE    = 8'h00,
    RESP_AERROR  = 8'h01,
    RESP_DERROR  = 8'h03,
    RESP_NLOCK   = 8'h04,
    RESP_NRES    = 8'h05,
    RESP_FLUSHED = 8'h06,
    RESP_FAULT   = 8'h07,
    RESP_FAILED  = 8'h08,
    RESP_PAGED   = 8'h0a
  } resp_code_t;

  typedef struct packed {
    logic       valid;
    tag_t       tag;
    cmd_class_t cmd_class;
  } cmd_issue_t;

  typedef struct packed {
    logic       valid;
    tag_t       tag;
    logic       tag_parity;
    resp_code_t code;
    credits_t   credits;
  } host_response_t;

  // One-hot class pulse plus the forwarded response fields
  typedef struct packed {
    logic                   valid;
    logic [NUM_CLASSES-1:0] pulse;
    tag_t                   tag;
    cmd_class_t             cmd_class;
    resp_code_t             code;
    credits_t               credits;
  } routed_response_t;

  typedef struct packed {
    logic tag_parity_error;
    logic aerror;
    logic derror;
    logic flushed;
    logic fault;
    logic failed;
    logic paged;
  } resp_error_t;

  // Bit that gives the tag plus itself an odd count of ones
  function automatic logic odd_parity(tag_t tag);
    return ~(^tag);
  endfunction

  // Error bits in resp_error_t order, aerror first
  function automatic logic [5:0] code_errors(resp_code_t code);
    logic [5:0] bits;
    bits = '0;
    case (code)
      RESP_AERROR:  bits[5] = 1'b1;
      RESP_DERROR:  bits[4] = 1'b1;
      RESP_FLUSHED: bits[3] = 1'b1;
      RESP_FAULT:   bits[2] = 1'b1;
      RESP_FAILED:  bits[1] = 1'b1;
      RESP_PAGED:   bits[0] = 1'b1;
      default:      bits    = '0;
    endcase
    return bits;
  endfunction

endpackage

// ==== design/tag_table.sv ====
// Tag to command class table
`timescale 1ns/100ps

module tag_table
  import resp_pkg::*;
(
  input  logic       clock,
  input  logic       rstn,
  input  cmd_issue_t issue,
  input  logic       lookup_valid,
  input  tag_t       lookup_tag,
  output cmd_class_t lookup_class
);

  localparam int TAG_DEPTH = 1 << $bits(tag_t);

  cmd_class_t class_mem [0:TAG_DEPTH-1];

  // Issue side, one entry per tag
  always_ff @(posedge clock) begin
    if (issue.valid) begin
      class_mem[issue.tag] <= issue.cmd_class;
    end
  end

  // Registered lookup, old contents win on a same-cycle write
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      lookup_class <= CMD_READ;
    end else if (lookup_valid) begin
      lookup_class <= class_mem[lookup_tag];
    end
  end

endmodule

// ==== design/response_control.sv ====
// Response classification and error detection
`timescale 1ns/100ps

module response_control
  import resp_pkg::*;
(
  input  logic             clock,
  input  logic             rstn,
  input  logic             enable,
  input  host_response_t   response,
  input  cmd_class_t       tag_class,
  output routed_response_t routed,
  output resp_error_t      resp_error
);

  logic             enabled;
  host_response_t   resp_in;
  logic             parity_in;
  logic [NUM_CLASSES-1:0] class_pulse;
  routed_response_t decoded;
  logic             decoded_parity;
  routed_response_t delayed;
  logic             delayed_parity;
  resp_error_t      error_q;

  ////////////////////////////////////////
  // Enable and input latch
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enabled <= 1'b0;
    end else begin
      enabled <= enable;
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      resp_in   <= '0;
      parity_in <= 1'b1;
    end else if (enabled && response.valid) begin
      resp_in   <= response;
      parity_in <= response.tag_parity;
    end else begin
      resp_in   <= '0;
      // Odd default while idle
      parity_in <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // Class decode
  ////////////////////////////////////////

  // Invalid classes leave the vector empty
  always_comb begin
    class_pulse = '0;
    if (int'(tag_class) < NUM_CLASSES) begin
      class_pulse[tag_class] = 1'b1;
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      decoded        <= '0;
      decoded_parity <= 1'b1;
    end else if (enabled && resp_in.valid) begin
      decoded.valid     <= 1'b1;
      decoded.pulse     <= class_pulse;
      decoded.tag       <= resp_in.tag;
      decoded.cmd_class <= tag_class;
      decoded.code      <= resp_in.code;
      decoded.credits   <= resp_in.credits;
      decoded_parity    <= parity_in;
    end else begin
      decoded        <= '0;
      decoded_parity <= 1'b1;
    end
  end

  // Extra stage so the record leaves with the data path
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      delayed        <= '0;
      delayed_parity <= 1'b1;
      routed         <= '0;
    end else if (enabled) begin
      delayed        <= decoded;
      delayed_parity <= decoded_parity;
      routed         <= delayed;
    end else begin
      delayed        <= '0;
      delayed_parity <= 1'b1;
      routed         <= '0;
    end
  end

  ////////////////////////////////////////
  // Error vector
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      error_q    <= '0;
      resp_error <= '0;
    end else begin
      if (enabled && delayed.valid) begin
        error_q <= {odd_parity(delayed.tag) ^ delayed_parity, code_errors(delayed.code)};
      end else begin
        error_q <= '0;
      end
      resp_error <= error_q;
    end
  end

endmodule

// ==== design/response_channel.sv ====
// Outstanding command counter per class
`timescale 1ns/100ps

module response_channel
  import resp_pkg::*;
#(
  parameter int         CREDIT_WIDTH = 8,
  parameter cmd_class_t CLASS        = CMD_READ
) (
  input  logic                  clock,
  input  logic                  rstn,
  input  cmd_issue_t            issue,
  input  logic                  response_pulse,
  output logic [CREDIT_WIDTH:0] status
);

  typedef struct packed {
    logic [CREDIT_WIDTH-1:0] count;
    logic                    underflow;
  } channel_status_t;

  channel_status_t status_q;
  logic            issue_hit;

  assign issue_hit = issue.valid && (issue.cmd_class == CLASS);

  // Issue and response in one cycle cancel out
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      status_q <= '0;
    end else if (issue_hit && !response_pulse) begin
      if (status_q.count != {CREDIT_WIDTH{1'b1}}) begin
        status_q.count <= status_q.count + 1'b1;
      end
    end else if (response_pulse && !issue_hit) begin
      if (status_q.count == '0) begin
        status_q.underflow <= 1'b1;
      end else begin
        status_q.count <= status_q.count - 1'b1;
      end
    end
  end

  assign status = status_q;

endmodule

// ==== design/status_collector.sv ====
// Busy flag and error summary
`timescale 1ns/100ps

module status_collector
  import resp_pkg::*;
#(
  parameter int CREDIT_WIDTH = 8
) (
  input  logic                                    clock,
  input  logic                                    rstn,
  input  logic [NUM_CLASSES-1:0][CREDIT_WIDTH:0] channel_status,
  input  resp_error_t                             resp_error,
  output logic                                    busy,
  output resp_error_t                             error_summary,
  output logic [15:0]                             error_count
);

  typedef struct packed {
    logic [CREDIT_WIDTH-1:0] count;
    logic                    underflow;
  } channel_status_t;

  channel_status_t ch;
  logic            any_pending;

  always_comb begin
    any_pending = 1'b0;
    for (int k = 0; k < NUM_CLASSES; k++) begin
      ch          = channel_status[k];
      any_pending = any_pending | (ch.count != '0);
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      busy          <= 1'b0;
      error_summary <= '0;
      error_count   <= '0;
    end else begin
      busy          <= any_pending;
      error_summary <= error_summary | resp_error;
      // Saturating count of error cycles
      if (resp_error != '0 && error_count != 16'hffff) begin
        error_count <= error_count + 16'd1;
      end
    end
  end

endmodule

// ==== design/response_subsystem.sv ====
// Response subsystem top level
`timescale 1ns/100ps

module response_subsystem
  import resp_pkg::*;
#(
  parameter int CREDIT_WIDTH = 8
) (
  input  logic                                    clock,
  input  logic                                    rstn,
  input  cmd_issue_t                              issue,
  input  host_response_t                          response,
  input  logic                                    enable,
  output routed_response_t                        routed,
  output resp_error_t                             resp_error,
  output logic [NUM_CLASSES-1:0][CREDIT_WIDTH:0] channel_status,
  output logic                                    busy,
  output resp_error_t                             error_summary,
  output logic [15:0]                             error_count
);

  cmd_class_t tag_class;

  tag_table u_tag_table (
    .clock        (clock),
    .rstn         (rstn),
    .issue        (issue),
    .lookup_valid (response.valid),
    .lookup_tag   (response.tag),
    .lookup_class (tag_class)
  );

  response_control u_response_control (
    .clock      (clock),
    .rstn       (rstn),
    .enable     (enable),
    .response   (response),
    .tag_class  (tag_class),
    .routed     (routed),
    .resp_error (resp_error)
  );

  // One tracker per command class
  for (genvar k = 0; k < NUM_CLASSES; k++) begin : g_channel
    response_channel #(
      .CREDIT_WIDTH (CREDIT_WIDTH),
      .CLASS        (cmd_class_t'(k))
    ) u_channel (
      .clock          (clock),
      .rstn           (rstn),
      .issue          (issue),
      .response_pulse (routed.pulse[k]),
      .status         (channel_status[k])
    );
  end

  status_collector #(
    .CREDIT_WIDTH (CREDIT_WIDTH)
  ) u_status_collector (
    .clock          (clock),
    .rstn           (rstn),
    .channel_status (channel_status),
    .resp_error     (resp_error),
    .busy           (busy),
    .error_summary  (error_summary),
    .error_count    (error_count)
  );

endmodule

// ==== dv/response_subsystem_chk.sv ====
// Response subsystem assertions
`timescale 1ns/100ps

module response_subsystem_chk
  import resp_pkg::*;
(
  input logic             clock,
  input logic             rstn,
  input routed_response_t routed,
  input logic             busy,
  input resp_error_t      error_summary
);

  // At most one class line per response
  a_pulse_onehot: assert property (@(posedge clock) disable iff (!rstn)
    $onehot0(routed.pulse))
    else $error("Class pulse vector has more than one bit set");

  a_pulse_valid: assert property (@(posedge clock) disable iff (!rstn)
    (routed.pulse != '0) |-> routed.valid)
    else $error("Class pulse seen without routed valid");

  a_idle_after_reset: assert property (@(posedge clock) $rose(rstn) |=> !busy)
    else $error("Busy set right after reset release");

  // Summary is sticky
  a_summary_sticky: assert property (@(posedge clock) disable iff (!rstn)
    ($past(error_summary) & ~error_summary) == '0)
    else $error("Error summary bit cleared while out of reset");

endmodule

bind response_subsystem response_subsystem_chk u_chk (
  .clock         (clock),
  .rstn          (rstn),
  .routed        (routed),
  .busy          (busy),
  .error_summary (error_summary)
);

// ==== dv/tb_response_subsystem.sv ====
// Response subsystem testbench
`timescale 1ns/100ps

module tb_response_subsystem
  import resp_pkg::*;
();

  localparam int CREDIT_WIDTH   = 8;
  localparam int NUM_TESTS      = 6;
  localparam int CMDS_PER_TEST  = 16;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * CMDS_PER_TEST * 6 + 200;

  typedef logic [NUM_CLASSES-1:0][CREDIT_WIDTH:0] status_array_t;

  logic             clock;
  logic             rstn;
  cmd_issue_t       issue;
  host_response_t   response;
  logic             enable;
  routed_response_t routed;
  resp_error_t      resp_error;
  status_array_t    channel_status;
  logic             busy;
  resp_error_t      error_summary;
  logic [15:0]      error_count;

  // Reference model state
  logic [31:0]             lcg_state;
  string                   test_name;
  int                      cycle_count = 0;
  logic                    error_due;
  tag_t                    tag_list [CMDS_PER_TEST];
  cmd_class_t              class_of [256];
  logic [CREDIT_WIDTH-1:0] exp_count [NUM_CLASSES];
  logic                    exp_underflow [NUM_CLASSES];
  resp_error_t             exp_summary;
  logic [15:0]             exp_error_count;
  routed_response_t        routed_q [$];
  resp_error_t             error_q [$];
  resp_code_t              code_list [9] = '{RESP_DONE, RESP_AERROR, RESP_DERROR,
    RESP_NLOCK, RESP_NRES, RESP_FLUSHED, RESP_FAULT, RESP_FAILED, RESP_PAGED};

  response_subsystem #(
    .CREDIT_WIDTH (CREDIT_WIDTH)
  ) DUT (
    .clock          (clock),
    .rstn           (rstn),
    .issue          (issue),
    .response       (response),
    .enable         (enable),
    .routed         (routed),
    .resp_error     (resp_error),
    .channel_status (channel_status),
    .busy           (busy),
    .error_summary  (error_summary),
    .error_count    (error_count)
  );

  always #50 clock = ~clock;

  ////////////////////////////////////////
  // Helpers and reference model
  ////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic void expect_response(input host_response_t r,
                                          output routed_response_t er,
                                          output resp_error_t ee);
    cmd_class_t cls;
    logic       good_parity;
    cls           = class_of[r.tag];
    er            = '0;
    er.valid      = 1'b1;
    er.pulse[cls] = 1'b1;
    er.tag        = r.tag;
    er.cmd_class  = cls;
    er.code       = r.code;
    er.credits    = r.credits;
    // Tag plus parity bit holds an odd number of ones
    good_parity         = ($countones(r.tag) % 2 == 0);
    ee                  = '0;
    ee.tag_parity_error = (r.tag_parity != good_parity);
    ee.aerror           = (r.code == RESP_AERROR);
    ee.derror           = (r.code == RESP_DERROR);
    ee.flushed          = (r.code == RESP_FLUSHED);
    ee.fault            = (r.code == RESP_FAULT);
    ee.failed           = (r.code == RESP_FAILED);
    ee.paged            = (r.code == RESP_PAGED);
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic compare_routed(input string name, input routed_response_t exp,
                                input routed_response_t act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic compare_error(input string name, input resp_error_t exp,
                               input resp_error_t act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic compare_status(input string name, input status_array_t exp,
                                input status_array_t act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic compare_count(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic issue_batch(input int n, input bit reuse);
    tag_t       base;
    cmd_class_t cls;
    base = tag_t'(next_rand() >> 20);
    for (int i = 0; i < n; i++) begin
      if (!reuse) begin
        tag_list[i] = base + tag_t'(i * 37);
        cls = cmd_class_t'((next_rand() >> 16) % NUM_CLASSES);
      end else begin
        // Move the tag to some other class
        cls = cmd_class_t'((int'(class_of[tag_list[i]]) + 1 + (next_rand() >> 16) % 5)
                           % NUM_CLASSES);
      end
      @(negedge clock);
      issue.valid     = 1'b1;
      issue.tag       = tag_list[i];
      issue.cmd_class = cls;
      class_of[tag_list[i]] = cls;
      if (exp_count[cls] != '1) begin
        exp_count[cls]++;
      end
    end
    @(negedge clock);
    issue = '0;
  endtask

  // Mode 0 random codes, 1 bad parity on odd entries, 2 every code in turn
  task automatic respond_batch(input int n, input int mode);
    host_response_t   r;
    routed_response_t er;
    resp_error_t      ee;
    cmd_class_t       cls;
    for (int i = 0; i < n; i++) begin
      r.valid      = 1'b1;
      r.tag        = tag_list[i];
      r.credits    = credits_t'(next_rand() >> 16);
      r.code       = (mode == 2) ? code_list[i % 9] : code_list[(next_rand() >> 16) % 9];
      r.tag_parity = ($countones(r.tag) % 2 == 0);
      if (mode == 1 && i % 2 == 1) begin
        r.tag_parity = ~r.tag_parity;
      end
      @(negedge clock);
      response = r;
      if (enable) begin
        expect_response(r, er, ee);
        routed_q.push_back(er);
        error_q.push_back(ee);
        exp_summary = exp_summary | ee;
        if (ee != '0) begin
          exp_error_count++;
        end
        cls = class_of[r.tag];
        if (exp_count[cls] == '0) begin
          exp_underflow[cls] = 1'b1;
        end else begin
          exp_count[cls]--;
        end
      end
    end
    @(negedge clock);
    response = '0;
  endtask

  task automatic settle_and_check();
    status_array_t exp_status;
    logic          exp_busy;
    while (routed_q.size() != 0 || error_q.size() != 0) begin
      @(negedge clock);
    end
    // Counts, then busy and the summary, settle one edge apart
    repeat (3) @(negedge clock);
    exp_busy = 1'b0;
    for (int k = 0; k < NUM_CLASSES; k++) begin
      exp_status[k] = {exp_count[k], exp_underflow[k]};
      exp_busy      = exp_busy | (exp_count[k] != '0);
    end
    compare_status({test_name, " status"}, exp_status, channel_status);
    compare_bit({test_name, " busy"}, exp_busy, busy);
    compare_error({test_name, " summary"}, exp_summary, error_summary);
    compare_count({test_name, " error count"}, exp_error_count, error_count);
  endtask

  ////////////////////////////////////////
  // Compare process and timeout
  ////////////////////////////////////////

  always @(negedge clock) begin
    routed_response_t exp_routed;
    resp_error_t      exp_error;
    if (!rstn) begin
      error_due = 1'b0;
    end else begin
      // Error vector trails the routed pulse by one cycle
      exp_error = '0;
      if (error_due && error_q.size() != 0) begin
        exp_error = error_q.pop_front();
      end
      compare_error({test_name, " error"}, exp_error, resp_error);
      error_due = routed.valid;
      if (routed.valid) begin
        if (routed_q.size() == 0) begin
          abort_run($sformatf("Unexpected routed response during %s", test_name));
        end else begin
          exp_routed = routed_q.pop_front();
          compare_routed({test_name, " routed"}, exp_routed, routed);
        end
      end
    end
  end

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      abort_run($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    clock           = 1'b0;
    rstn            = 1'b0;
    issue           = '0;
    response        = '0;
    enable          = 1'b0;
    lcg_state       = 32'h0c24_ad3c;
    error_due       = 1'b0;
    exp_summary     = '0;
    exp_error_count = '0;
    for (int k = 0; k < NUM_CLASSES; k++) begin
      exp_count[k]     = '0;
      exp_underflow[k] = 1'b0;
    end
    test_name = "reset";
    repeat (3) @(negedge clock);
    rstn   = 1'b1;
    enable = 1'b1;
    repeat (2) @(negedge clock);
    settle_and_check();

    test_name = "classify";
    issue_batch(CMDS_PER_TEST, 1'b0);
    settle_and_check();
    respond_batch(CMDS_PER_TEST, 0);
    settle_and_check();

    test_name = "tag_reuse";
    issue_batch(8, 1'b0);
    respond_batch(8, 0);
    settle_and_check();
    issue_batch(8, 1'b1);
    respond_batch(8, 0);
    settle_and_check();

    test_name = "parity";
    issue_batch(CMDS_PER_TEST, 1'b0);
    respond_batch(CMDS_PER_TEST, 1);
    settle_and_check();

    test_name = "code_errors";
    issue_batch(9, 1'b0);
    respond_batch(9, 2);
    settle_and_check();

    // Gated responses leave counts and errors alone
    test_name = "enable_gating";
    issue_batch(4, 1'b0);
    enable = 1'b0;
    repeat (2) @(negedge clock);
    respond_batch(4, 0);
    settle_and_check();
    enable = 1'b1;
    repeat (2) @(negedge clock);
    respond_batch(4, 0);
    settle_and_check();

    test_name = "underflow";
    issue_batch(1, 1'b0);
    respond_batch(1, 0);
    respond_batch(1, 0);
    settle_and_check();

    $display("Test OK");
    $finish;
  end

endmodule

// ==== project.f ====
design/resp_pkg.sv
design/tag_table.sv
design/response_control.sv
design/response_channel.sv
design/status_collector.sv
design/response_subsystem.sv
dv/response_subsystem_chk.sv
dv/tb_response_subsystem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_response_subsystem
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Test OK" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
